// File: hdl/rvTypes.sv
package rvTypes;

    // architectural widths
    typedef logic [63:0] xlenWord;   // data and address word
    typedef logic [31:0] instWord;
    typedef logic [4:0]  regAddr;
    typedef logic [7:0]  byteMask;   // one enable per byte lane

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opImm32  = 7'b0011011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opReg32  = 7'b0111011,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

endpackage

// File: hdl/rvCtrl.sv
package rvCtrl;

    // immediate layout picked by the decoder
    typedef enum logic [2:0] {
        immFmtNone,
        immFmtI,
        immFmtS,
        immFmtB,
        immFmtU,
        immFmtJ
    } immFmtT;

    // access size, funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        szByte   = 2'd0,
        szHalf   = 2'd1,
        szWord   = 2'd2,
        szDouble = 2'd3
    } memWidthT;

    typedef struct packed {
        rvTypes::opcodeT  opcode;
        logic [2:0]       funct3;
        logic [6:0]       funct7;
        rvTypes::regAddr  rd;
        rvTypes::regAddr  rs1Addr;
        rvTypes::regAddr  rs2Addr;
        rvTypes::xlenWord imm;       // sign-extended for the format
        logic             illegal;
    } decodedInst;

    typedef struct packed {
        rvTypes::xlenWord addr;
        rvTypes::xlenWord wdata;     // already shifted into its lanes
        rvTypes::byteMask mask;
        logic             write;
    } memReq;

    // one retired instruction
    typedef struct packed {
        logic             valid;
        rvTypes::xlenWord pc;
        rvTypes::regAddr  rd;
        logic             wen;
        rvTypes::xlenWord wdata;
        logic             illegal;
    } commitInfo;

endpackage

// File: hdl/InstDecoder.sv
`timescale 1ns/1ns

module InstDecoder
    import rvTypes::*;
    import rvCtrl::*;
(
    input  instWord    inst,
    output decodedInst dec
);
    logic [2:0] funct3;
    logic [6:0] funct7;
    immFmtT     immFmt;
    logic       illegal;
    xlenWord    immI;
    xlenWord    immS;
    xlenWord    immB;
    xlenWord    immU;
    xlenWord    immJ;
    xlenWord    imm;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        immFmt  = immFmtNone;
        illegal = 1'b0;
        case (inst[6:0])
            opLoad: begin
                immFmt  = immFmtI;
                illegal = (funct3 == 3'b111);   // no ldu
            end
            opStore: begin
                immFmt  = immFmtS;
                illegal = funct3[2];
            end
            opImm: begin
                immFmt = immFmtI;
                if (funct3 == 3'b001) begin
                    illegal = (funct7[6:1] != 6'b000000);   // shamt takes bit 25
                end else if (funct3 == 3'b101) begin
                    illegal = !(funct7[6:1] inside {6'b000000, 6'b010000});
                end
            end
            opImm32: begin
                immFmt = immFmtI;
                case (funct3)
                    3'b000:  illegal = 1'b0;
                    3'b001:  illegal = (funct7 != 7'b0000000);
                    3'b101:  illegal = !(funct7 inside {7'b0000000, 7'b0100000});
                    default: illegal = 1'b1;
                endcase
            end
            opReg: begin
                case (funct7)
                    7'b0000000: illegal = 1'b0;
                    7'b0100000: illegal = !(funct3 inside {3'b000, 3'b101});
                    7'b0000001: illegal = (funct3 != 3'b000);   // mul only
                    default:    illegal = 1'b1;
                endcase
            end
            opReg32: begin
                case (funct7)
                    7'b0000000: illegal = !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'b0100000: illegal = !(funct3 inside {3'b000, 3'b101});
                    7'b0000001: illegal = (funct3 != 3'b000);   // divw, remw land here
                    default:    illegal = 1'b1;
                endcase
            end
            opLui, opAuipc: immFmt = immFmtU;
            opJal:          immFmt = immFmtJ;
            opJalr: begin
                immFmt  = immFmtI;
                illegal = (funct3 != 3'b000);
            end
            opBranch: begin
                immFmt  = immFmtB;
                illegal = (funct3 inside {3'b010, 3'b011});
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        case (immFmt)
            immFmtI: imm = immI;
            immFmtS: imm = immS;
            immFmtB: imm = immB;
            immFmtU: imm = immU;
            immFmtJ: imm = immJ;
            default: imm = '0;
        endcase
    end

    assign dec.opcode  = opcodeT'(inst[6:0]);
    assign dec.funct3  = funct3;
    assign dec.funct7  = funct7;
    assign dec.rd      = inst[11:7];
    assign dec.rs1Addr = inst[19:15];
    assign dec.rs2Addr = inst[24:20];
    assign dec.imm     = imm;
    assign dec.illegal = illegal;

endmodule

// File: hdl/ExecUnit.sv
`timescale 1ns/1ns

module ExecUnit
    import rvTypes::*;
    import rvCtrl::*;
(
    input  decodedInst dec,
    input  xlenWord    pc,
    input  xlenWord    rs1Val,
    input  xlenWord    rs2Val,
    input  xlenWord    loadWord,
    output logic       wen,
    output xlenWord    wdata,
    output xlenWord    nextPc,
    output memReq      mreq
);
    xlenWord     opB;
    xlenWord     addr;         // rs1 + imm, also the jalr target
    xlenWord     pcPlus4;
    xlenWord     pcTarget;
    xlenWord     aluRes;
    xlenWord     aluWord;
    xlenWord     loadShift;
    xlenWord     loadVal;
    logic [31:0] word32;
    logic [5:0]  shamt;
    logic        isReg;
    logic        taken;
    byteMask     sizeMask;
    memWidthT    width;

    assign isReg    = (dec.opcode == opReg) || (dec.opcode == opReg32);
    assign opB      = isReg ? rs2Val : dec.imm;
    assign shamt    = opB[5:0];
    assign addr     = rs1Val + dec.imm;
    assign pcPlus4  = pc + 64'd4;
    assign pcTarget = pc + dec.imm;
    assign width    = memWidthT'(dec.funct3[1:0]);

    always_comb begin
        case (dec.funct3)
            3'b000: begin
                if (isReg && dec.funct7[5]) aluRes = rs1Val - opB;
                else if (isReg && dec.funct7[0]) aluRes = rs1Val * opB;
                else aluRes = rs1Val + opB;
            end
            3'b001:  aluRes = rs1Val << shamt;
            3'b010:  aluRes = {63'b0, $signed(rs1Val) < $signed(opB)};
            3'b011:  aluRes = {63'b0, rs1Val < opB};
            3'b100:  aluRes = rs1Val ^ opB;
            3'b101:  aluRes = dec.funct7[5] ? xlenWord'($signed(rs1Val) >>> shamt) : rs1Val >> shamt;
            3'b110:  aluRes = rs1Val | opB;
            default: aluRes = rs1Val & opB;
        endcase
    end

    // word forms work on the low half
    always_comb begin
        case (dec.funct3)
            3'b000: begin
                if (isReg && dec.funct7[5]) word32 = rs1Val[31:0] - opB[31:0];
                else if (isReg && dec.funct7[0]) word32 = rs1Val[31:0] * opB[31:0];
                else word32 = rs1Val[31:0] + opB[31:0];
            end
            3'b001:  word32 = rs1Val[31:0] << shamt[4:0];
            default: begin
                if (dec.funct7[5]) word32 = $signed(rs1Val[31:0]) >>> shamt[4:0];
                else word32 = rs1Val[31:0] >> shamt[4:0];
            end
        endcase
        aluWord = {{32{word32[31]}}, word32};
    end

    // pick the addressed bytes, funct3[2] means zero extend
    assign loadShift = loadWord >> {addr[2:0], 3'b000};
    always_comb begin
        case (width)
            szByte:  loadVal = dec.funct3[2] ? {56'b0, loadShift[7:0]}
                                             : {{56{loadShift[7]}}, loadShift[7:0]};
            szHalf:  loadVal = dec.funct3[2] ? {48'b0, loadShift[15:0]}
                                             : {{48{loadShift[15]}}, loadShift[15:0]};
            szWord:  loadVal = dec.funct3[2] ? {32'b0, loadShift[31:0]}
                                             : {{32{loadShift[31]}}, loadShift[31:0]};
            default: loadVal = loadShift;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1Val == rs2Val);
            3'b001:  taken = (rs1Val != rs2Val);
            3'b100:  taken = ($signed(rs1Val) < $signed(rs2Val));
            3'b101:  taken = ($signed(rs1Val) >= $signed(rs2Val));
            3'b110:  taken = (rs1Val < rs2Val);
            3'b111:  taken = (rs1Val >= rs2Val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        wen    = !dec.illegal;
        wdata  = '0;
        nextPc = pcPlus4;
        case (dec.opcode)
            opLui:            wdata = dec.imm;
            opAuipc:          wdata = pcTarget;
            opLoad:           wdata = loadVal;
            opImm, opReg:     wdata = aluRes;
            opImm32, opReg32: wdata = aluWord;
            opJal: begin
                wdata = pcPlus4;
                if (!dec.illegal) nextPc = pcTarget;
            end
            opJalr: begin
                wdata = pcPlus4;
                if (!dec.illegal) nextPc = {addr[63:1], 1'b0};
            end
            opBranch: begin
                wen = 1'b0;
                if (!dec.illegal && taken) nextPc = pcTarget;
            end
            default: wen = 1'b0;   // stores and unknown opcodes
        endcase
    end

    always_comb begin
        case (width)
            szByte:  sizeMask = 8'h01;
            szHalf:  sizeMask = 8'h03;
            szWord:  sizeMask = 8'h0f;
            default: sizeMask = 8'hff;
        endcase
    end

    assign mreq.addr  = addr;
    assign mreq.wdata = rs2Val << {addr[2:0], 3'b000};
    assign mreq.mask  = sizeMask << addr[2:0];
    assign mreq.write = (dec.opcode == opStore) && !dec.illegal;

    // lanes must form one naturally sized run
    always_comb begin
        logic [8:0] maskExt;
        logic [8:0] maskCarry;
        maskExt   = {1'b0, mreq.mask};
        maskCarry = maskExt + (maskExt & (~maskExt + 9'd1));
        if (mreq.write) begin
            assert (((maskCarry & maskExt) == '0) && ($countones(mreq.mask) inside {1, 2, 4, 8}))
                else $error("store mask %b is not a contiguous 1, 2, 4 or 8 byte run", mreq.mask);
        end
    end

endmodule

// File: hdl/RegFile.sv
`timescale 1ns/1ns

module RegFile
    import rvTypes::*;
(
    input  logic    clk,
    input  logic    reset,
    input  regAddr  rs1Addr,
    input  regAddr  rs2Addr,
    input  regAddr  rd,
    input  logic    wen,       // already qualified by run
    input  xlenWord wdata,
    output xlenWord rs1Val,
    output xlenWord rs2Val
);
    xlenWord regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads zero
    assign rs1Val = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Val = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    x0Zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("x0 storage holds %h", regs[0]);

endmodule

// File: hdl/DataMem.sv
`timescale 1ns/1ns

module DataMem
    import rvTypes::*;
    import rvCtrl::*;
#(
    parameter int      memWords = 512,
    parameter xlenWord memBase  = 64'h8000_0000
) (
    input  logic    clk,
    input  memReq   mreq,
    input  logic    we,        // write strobe gated by run
    output xlenWord loadWord
);
    localparam int idxBits = $clog2(memWords);

    xlenWord              mem [memWords];
    xlenWord              offset;
    logic [idxBits-1:0]   wordIdx;

    assign offset  = mreq.addr - memBase;
    assign wordIdx = offset[idxBits+2:3];   // doubleword index

    assign loadWord = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 8; i++) begin
                if (mreq.mask[i]) begin
                    mem[wordIdx][i*8 +: 8] <= mreq.wdata[i*8 +: 8];
                end
            end
        end
    end

    // an enabled write must land inside the array
    writeInRange: assert property (@(posedge clk)
        we |-> ((offset >> 3) < xlenWord'(memWords)))
        else $error("store to %h outside data memory", mreq.addr);

endmodule

// File: hdl/CpuCore.sv
`timescale 1ns/1ns

module CpuCore
    import rvTypes::*;
    import rvCtrl::*;
#(
    parameter xlenWord resetPc  = 64'h8000_0000,
    parameter int      memWords = 512
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      run,
    output xlenWord   instAddr,
    input  instWord   inst,
    output commitInfo commit
);
    // data memory sits at the base of the region holding resetPc
    localparam xlenWord memBytes = xlenWord'(memWords) * 64'd8;
    localparam xlenWord memBase  = resetPc & ~(memBytes - 64'd1);

    xlenWord    pc;
    decodedInst dec;
    xlenWord    rs1Val;
    xlenWord    rs2Val;
    xlenWord    loadWord;
    logic       wen;
    xlenWord    wdata;
    xlenWord    nextPc;
    memReq      mreq;
    logic       regWen;
    logic       memWe;

    assign instAddr = pc;
    assign regWen   = run & wen;
    assign memWe    = run & mreq.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // trace of the instruction retired at the last edge
    always_ff @(posedge clk) begin
        if (reset) begin
            commit <= '0;
        end else begin
            commit.valid   <= run;
            commit.pc      <= pc;
            commit.rd      <= dec.rd;
            commit.wen     <= wen;
            commit.wdata   <= wdata;
            commit.illegal <= dec.illegal;
        end
    end

    InstDecoder u_InstDecoder (
        .inst (inst),
        .dec  (dec)
    );

    RegFile u_RegFile (
        .clk     (clk),
        .reset   (reset),
        .rs1Addr (dec.rs1Addr),
        .rs2Addr (dec.rs2Addr),
        .rd      (dec.rd),
        .wen     (regWen),
        .wdata   (wdata),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val)
    );

    ExecUnit u_ExecUnit (
        .dec      (dec),
        .pc       (pc),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .loadWord (loadWord),
        .wen      (wen),
        .wdata    (wdata),
        .nextPc   (nextPc),
        .mreq     (mreq)
    );

    DataMem #(
        .memWords (memWords),
        .memBase  (memBase)
    ) u_DataMem (
        .clk      (clk),
        .mreq     (mreq),
        .we       (memWe),
        .loadWord (loadWord)
    );

endmodule

// File: sim/CpuCoreTests.svh
task automatic clearProgram();
    for (int i = 0; i < 1024; i++) begin
        imem[i] = iType(12'(i), 5'd0, 3'b000, 5'd0, opImm);   // nop tagged with its slot
    end
    nExp   = 0;
    wrSlot = 0;
endtask

task automatic emit(input instWord i, input logic wen, input xlenWord d, input bit chk,
                    input logic ill);
    imem[wrSlot]  = i;
    expPc[nExp]   = resetPc + 64'(4 * wrSlot);
    expRd[nExp]   = i[11:7];
    expWen[nExp]  = wen;
    expData[nExp] = d;
    expChk[nExp]  = chk;
    expIll[nExp]  = ill;
    nExp++;
    wrSlot++;
endtask

task automatic emitW(input instWord i, input xlenWord d);
    emit(i, 1'b1, d, 1'b1, 1'b0);
endtask

task automatic place(input instWord i);
    imem[wrSlot] = i;   // fetched only if control flow lands here
    wrSlot++;
endtask

task automatic checkVal(input string name, input string what, input xlenWord exp,
                        input xlenWord act);
    checks++;
    assert (exp === act) else begin
        errors++;
        $display("CHECK FAILED %s %s expected %h actual %h", name, what, exp, act);
    end
endtask

task automatic doReset();
    reset = 1'b1;
    run   = 1'b0;
    repeat (10) @(posedge clk);
    #2 reset = 1'b0;
endtask

task automatic waitCommit(input string name, output bit seen);
    int t;
    t = 0;
    @(negedge clk);
    while (!commit.valid && t < timeoutCycles) begin
        @(negedge clk);
        t++;
    end
    seen = commit.valid;
    if (!seen) begin
        errors++;
        $display("%s: no commit seen within %0d cycles", name, timeoutCycles);
    end
endtask

task automatic runProgram(input string name);
    bit seen;
    @(posedge clk);
    #2 run = 1'b1;
    for (int i = 0; i < nExp; i++) begin
        waitCommit(name, seen);
        if (!seen) break;
        checkVal(name, "pc", expPc[i], commit.pc);
        if (expChk[i]) begin
            checkVal(name, "wen", 64'(expWen[i]), 64'(commit.wen));
            checkVal(name, "illegal", 64'(expIll[i]), 64'(commit.illegal));
            if (expWen[i]) begin
                checkVal(name, "wdata", expData[i], commit.wdata);
                checkVal(name, "rd", 64'(expRd[i]), 64'(commit.rd));
            end
        end
    end
    @(posedge clk);
    #2 run = 1'b0;
endtask

// builds v through addi, then slli and ori on 11 bit chunks
task automatic loadReg(input regAddr rd, input xlenWord v);
    xlenWord r;
    r = {55'b0, v[63:55]};
    emitW(iType({3'b0, v[63:55]}, 5'd0, 3'b000, rd, opImm), r);
    for (int k = 4; k >= 0; k--) begin
        r = r << 11;
        emitW(iType(12'd11, rd, 3'b001, rd, opImm), r);
        r = r | {53'b0, v[k*11 +: 11]};
        emitW(iType({1'b0, v[k*11 +: 11]}, rd, 3'b110, rd, opImm), r);
    end
endtask

task automatic testReset();
    clearProgram();
    emitW(uType(20'h12345, 5'd1, opLui), 64'h12345000);
    emitW(uType(20'h00001, 5'd2, opAuipc), resetPc + 64'h1004);
    doReset();
    checkVal("reset", "instAddr", resetPc, instAddr);
    repeat (5) begin
        @(negedge clk);
        checkVal("reset", "commit.valid", 64'd0, 64'(commit.valid));
    end
    runProgram("reset");
endtask

task automatic testArith();
    xlenWord a;
    xlenWord b;
    xlenWord immX;
    logic [5:0] sh;
    clearProgram();
    repeat (3) begin
        a    = rand64();
        b    = rand64();
        immX = {{52{a[11]}}, a[11:0]};
        sh   = b[13:8];
        loadReg(5'd1, a);
        loadReg(5'd2, b);
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, opReg), a + b);
        emitW(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, opReg), a - b);
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b001, 5'd3, opReg), a << b[5:0]);
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b010, 5'd3, opReg), 64'($signed(a) < $signed(b)));
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b011, 5'd3, opReg), 64'(a < b));
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b100, 5'd3, opReg), a ^ b);
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b101, 5'd3, opReg), a >> b[5:0]);
        emitW(rType(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, opReg), $signed(a) >>> b[5:0]);
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b110, 5'd3, opReg), a | b);
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b111, 5'd3, opReg), a & b);
        emitW(rType(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, opReg), a * b);
        emitW(iType(a[11:0], 5'd1, 3'b000, 5'd4, opImm), a + immX);
        emitW(iType(a[11:0], 5'd2, 3'b010, 5'd4, opImm), 64'($signed(b) < $signed(immX)));
        emitW(iType(a[11:0], 5'd2, 3'b011, 5'd4, opImm), 64'(b < immX));
        emitW(iType(a[11:0], 5'd2, 3'b100, 5'd4, opImm), b ^ immX);
        emitW(iType(a[11:0], 5'd2, 3'b110, 5'd4, opImm), b | immX);
        emitW(iType(a[11:0], 5'd2, 3'b111, 5'd4, opImm), b & immX);
        emitW(iType({6'b000000, sh}, 5'd1, 3'b001, 5'd4, opImm), a << sh);
        emitW(iType({6'b000000, sh}, 5'd1, 3'b101, 5'd4, opImm), a >> sh);
        emitW(iType({6'b010000, sh}, 5'd1, 3'b101, 5'd4, opImm), $signed(a) >>> sh);
    end
    doReset();
    runProgram("arith");
endtask

task automatic testWord();
    xlenWord a;
    xlenWord b;
    logic [4:0] sh;
    clearProgram();
    repeat (3) begin
        a  = rand64() | 64'h8000_0000;   // bit 31 set for sign extension
        b  = rand64() | 64'h8000_0000;
        sh = b[12:8];
        loadReg(5'd1, a);
        loadReg(5'd2, b);
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, opReg32), sext32(a[31:0] + b[31:0]));
        emitW(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, opReg32), sext32(a[31:0] - b[31:0]));
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b001, 5'd3, opReg32), sext32(a[31:0] << b[4:0]));
        emitW(rType(7'h00, 5'd2, 5'd1, 3'b101, 5'd3, opReg32), sext32(a[31:0] >> b[4:0]));
        emitW(rType(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, opReg32),
              sext32($signed(a[31:0]) >>> b[4:0]));
        emitW(rType(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, opReg32), sext32(a[31:0] * b[31:0]));
        emitW(iType(b[11:0], 5'd1, 3'b000, 5'd4, opImm32),
              sext32(a[31:0] + {{20{b[11]}}, b[11:0]}));
        emitW(iType({7'h00, sh}, 5'd1, 3'b001, 5'd4, opImm32), sext32(a[31:0] << sh));
        emitW(iType({7'h00, sh}, 5'd1, 3'b101, 5'd4, opImm32), sext32(a[31:0] >> sh));
        emitW(iType({7'h20, sh}, 5'd1, 3'b101, 5'd4, opImm32),
              sext32($signed(a[31:0]) >>> sh));
    end
    doReset();
    runProgram("word");
endtask

task automatic testMem();
    logic [7:0] memModel [8];
    xlenWord v;
    xlenWord w;
    xlenWord exp;
    int nb;
    clearProgram();
    emitW(iType(12'd1, 5'd0, 3'b000, 5'd10, opImm), 64'd1);
    emitW(iType(12'd31, 5'd10, 3'b001, 5'd10, opImm), resetPc);   // x10 = data base
    for (int s = 0; s < 4; s++) begin
        for (int o = 0; o < 8; o += (1 << s)) begin
            v = rand64();
            w = rand64();
            loadReg(5'd5, v);
            emit(sType(12'd0, 5'd5, 5'd10, 3'b011), 1'b0, '0, 1'b1, 1'b0);
            for (int i = 0; i < 8; i++) memModel[i] = v[i*8 +: 8];
            loadReg(5'd6, w);
            emit(sType(12'(o), 5'd6, 5'd10, 3'(s)), 1'b0, '0, 1'b1, 1'b0);
            for (int i = 0; i < (1 << s); i++) memModel[o + i] = w[i*8 +: 8];
            for (int ls = 0; ls < 4; ls++) begin
                for (int u = 0; u < 2; u++) begin
                    nb = 1 << ls;
                    if ((o % nb) == 0 && !(ls == 3 && u == 1)) begin
                        exp = '0;
                        for (int i = 0; i < nb; i++) exp[i*8 +: 8] = memModel[o + i];
                        if (u == 0) begin
                            for (int j = nb * 8; j < 64; j++) exp[j] = exp[nb*8 - 1];
                        end
                        emitW(iType(12'(o), 5'd10, {1'(u), 2'(ls)}, 5'd7, opLoad), exp);
                    end
                end
            end
        end
    end
    emit(iType(12'd0, 5'd10, 3'b000, 5'd0, opLoad), 1'b1, '0, 1'b0, 1'b0);
    emitW(rType(7'h00, 5'd0, 5'd0, 3'b000, 5'd8, opReg), 64'd0);   // x0 still reads zero
    doReset();
    runProgram("mem");
endtask

task automatic testBranch();
    logic [2:0] conds [6];
    xlenWord a;
    xlenWord pcQ;
    regAddr rs1;
    logic taken;
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    clearProgram();
    emitW(iType(12'hfff, 5'd0, 3'b000, 5'd1, opImm), '1);
    emitW(iType(12'd1, 5'd0, 3'b000, 5'd2, opImm), 64'd1);
    for (int p = 0; p < 3; p++) begin
        a   = (p == 0) ? '1 : ((p == 1) ? 64'd1 : 64'd0);   // rs1 is x1, x2, then x0
        rs1 = (p == 0) ? 5'd1 : ((p == 1) ? 5'd2 : 5'd0);   // rs2 is always x2
        foreach (conds[c]) begin
            case (conds[c])
                3'b000:  taken = (a == 64'd1);
                3'b001:  taken = (a != 64'd1);
                3'b100:  taken = ($signed(a) < 64'sd1);
                3'b101:  taken = ($signed(a) >= 64'sd1);
                3'b110:  taken = (a < 64'd1);
                default: taken = (a >= 64'd1);
            endcase
            emit(bType(13'd8, 5'd2, rs1, conds[c]), 1'b0, '0, 1'b1, 1'b0);
            if (taken) place(iType(12'd99, 5'd0, 3'b000, 5'd9, opImm));
            else emitW(iType(12'd99, 5'd0, 3'b000, 5'd9, opImm), 64'd99);
        end
    end
    emitW(jType(21'd12, 5'd5), resetPc + 64'(4 * wrSlot) + 64'd4);
    place(iType(12'd98, 5'd0, 3'b000, 5'd9, opImm));
    place(iType(12'd98, 5'd0, 3'b000, 5'd9, opImm));
    pcQ = resetPc + 64'(4 * wrSlot);
    emitW(uType(20'd0, 5'd6, opAuipc), pcQ);
    emitW(iType(12'd13, 5'd6, 3'b000, 5'd7, opJalr), pcQ + 64'd8);   // lands on pcQ + 12
    place(iType(12'd98, 5'd0, 3'b000, 5'd9, opImm));
    emitW(iType(12'd97, 5'd0, 3'b000, 5'd9, opImm), 64'd97);
    doReset();
    runProgram("branch");
endtask

task automatic testIllegal();
    xlenWord held;
    clearProgram();
    emitW(iType(12'd7, 5'd0, 3'b000, 5'd1, opImm), 64'd7);
    emitW(iType(12'd2, 5'd0, 3'b000, 5'd2, opImm), 64'd2);
    emit(rType(7'h01, 5'd2, 5'd1, 3'b100, 5'd3, opReg32), 1'b0, '0, 1'b1, 1'b1);   // divw
    emit(32'h0000_01ff, 1'b0, '0, 1'b1, 1'b1);
    emitW(iType(12'd5, 5'd0, 3'b000, 5'd4, opImm), 64'd5);
    doReset();
    runProgram("illegal");
    @(posedge clk);
    #2 run = 1'b1;
    repeat (3) @(posedge clk);
    #2 run = 1'b0;
    held = instAddr;
    @(posedge clk);
    repeat (6) begin
        @(negedge clk);
        checkVal("hold", "commit.valid", 64'd0, 64'(commit.valid));
        checkVal("hold", "instAddr", held, instAddr);
    end
endtask

// File: sim/CpuCoreTb.sv
`timescale 1ns/1ns

module CpuCoreTb
    import rvTypes::*;
    import rvCtrl::*;
();
    localparam xlenWord resetPc       = 64'h8000_0000;
    localparam int      timeoutCycles = 50;

    logic      clk;
    logic      reset;
    logic      run;
    xlenWord   instAddr;
    instWord   inst;
    commitInfo commit;

    instWord imem [1024];
    xlenWord expPc [1024];
    xlenWord expData [1024];
    regAddr  expRd [1024];
    logic    expWen [1024];
    logic    expIll [1024];
    bit      expChk [1024];   // 0 means only the pc is compared
    int      nExp;
    int      wrSlot;
    int      errors;
    int      checks;
    logic [31:0] lcgState;

    CpuCore #(
        .resetPc  (resetPc),
        .memWords (512)
    ) u_CpuCore (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .instAddr (instAddr),
        .inst     (inst),
        .commit   (commit)
    );

    assign inst = imem[10'((instAddr - resetPc) >> 2)];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function xlenWord rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcgNext();
        lo = lcgNext();
        return {hi, lo};
    endfunction

    function xlenWord sext32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function instWord rType(input logic [6:0] f7, input regAddr rs2, input regAddr rs1,
                            input logic [2:0] f3, input regAddr rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function instWord iType(input logic [11:0] imm, input regAddr rs1, input logic [2:0] f3,
                            input regAddr rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function instWord sType(input logic [11:0] imm, input regAddr rs2, input regAddr rs1,
                            input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function instWord bType(input logic [12:0] imm, input regAddr rs2, input regAddr rs1,
                            input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function instWord uType(input logic [19:0] imm, input regAddr rd, input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function instWord jType(input logic [20:0] imm, input regAddr rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    `include "CpuCoreTests.svh"

    initial begin
        reset    = 1'b1;
        run      = 1'b0;
        errors   = 0;
        checks   = 0;
        lcgState = 32'd86613;
        testReset();
        testArith();
        testWord();
        testMem();
        testBranch();
        testIllegal();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: CpuCore.f
+incdir+sim
hdl/rvTypes.sv
hdl/rvCtrl.sv
hdl/InstDecoder.sv
hdl/ExecUnit.sv
hdl/RegFile.sv
hdl/DataMem.sv
hdl/CpuCore.sv
sim/CpuCoreTb.sv

// File: runSim.sh
#!/bin/bash
# build and run the CpuCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f CpuCore.f --top-module CpuCoreTb \
    -o CpuCoreSim \
    && ./obj_dir/CpuCoreSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
